// File: Makefile
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetchTb
RTL_TOP   ?= fetchUnit
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

SOURCES := $(wildcard design/*.sv bench/*.sv include/*.svh) bench/fetch_tests.txt

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fetchChecker.sv
// compares one named fetch unit output per step, 25 ns after the rising edge
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetchChecker (
  input  logic              clk,
  input  logic              stepValid,
  input  logic [8*16-1:0]   testName,
  input  logic [8*8-1:0]    sigSel,
  input  logic [31:0]       expVal,
  input  logic [`XLEN-1:0]  pcF,
  input  logic [`XLEN-1:0]  pcE,
  input  logic [`XLEN-1:0]  pcLinkE,
  input  logic [`XLEN-1:0]  pcM,
  input  logic [31:0]       instrD,
  input  logic [31:0]       instrM,
  input  logic [4:0]        instrClassM,
  input  logic              illegalInstrFaultD,
  input  logic              mispredictE,
  input  logic              fetchStall,
  input  logic              misalignedFaultM,
  input  logic [`XLEN-1:0]  misalignedAdrM,
  output int                checkedCount,
  output int                errorCount
);

  initial begin
    checkedCount = 0;
    errorCount   = 0;
  end

  //////////////////////////////
  // sample and compare
  //////////////////////////////

  always @(posedge clk) begin
    logic [31:0] actual;
    bit known;
    if (stepValid) begin
      // mid high phase, registers settled and inputs not yet changed
      #25;
      known = 1'b1;
      case (sigSel)
        "pcF":     actual = pcF;
        "pcE":     actual = pcE;
        "pcLinkE": actual = pcLinkE;
        "pcM":     actual = pcM;
        "instrD":  actual = instrD;
        "instrM":  actual = instrM;
        "classM":  actual = {27'd0, instrClassM};
        "illegal": actual = {31'd0, illegalInstrFaultD};
        "mispred": actual = {31'd0, mispredictE};
        "fstall":  actual = {31'd0, fetchStall};
        "misF":    actual = {31'd0, misalignedFaultM};
        "misAdr":  actual = misalignedAdrM;
        default: begin
          actual = '0;
          known  = 1'b0;
        end
      endcase
      if (!known) begin
        $display("test %0s names a signal the checker does not know: %0s", testName, sigSel);
        errorCount++;
      end else if (actual !== expVal) begin
        $display("FAILED %0s %0s expected %h actual %h", testName, sigSel, expVal, actual);
        errorCount++;
      end else begin
        $display("passed %0s", testName);
      end
      checkedCount++;
    end
  end

endmodule

`default_nettype wire

// File: bench/fetchTb.sv
// fetch unit testbench; reads bench/fetch_tests.txt from the project root, one clock per line
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetchTb;

  localparam int resetCycles = 16;
  localparam int waitLimit   = 20;

  logic clk;
  logic rst;
  logic stallF, stallD, stallE, stallM;
  logic flushD, flushE, flushM;
  logic [31:0] instrIn;
  logic instrAck, instrRead, fetchStall;
  logic pcSrcE, mispredictE, retM, trapM;
  logic [`XLEN-1:0] pcF, pcTargetE, pcE, pcLinkE, pcM, privilegedNextPcM, misalignedAdrM;
  logic [31:0] instrD, instrM;
  logic [4:0] instrClassM;
  logic illegalBaseFaultD, illegalInstrFaultD, misalignedFaultM;

  // one step as handed to the checker
  logic [8*16-1:0] testName;
  logic [8*8-1:0] sigSel;
  logic [31:0] expVal;
  logic stepValid;
  int checkedCount;
  int errorCount;

  fetchUnit uut (.*);

  fetchChecker check (
    .clk(clk), .stepValid(stepValid), .testName(testName), .sigSel(sigSel),
    .expVal(expVal), .pcF(pcF), .pcE(pcE), .pcLinkE(pcLinkE), .pcM(pcM),
    .instrD(instrD), .instrM(instrM), .instrClassM(instrClassM),
    .illegalInstrFaultD(illegalInstrFaultD), .mispredictE(mispredictE),
    .fetchStall(fetchStall), .misalignedFaultM(misalignedFaultM),
    .misalignedAdrM(misalignedAdrM), .checkedCount(checkedCount), .errorCount(errorCount)
  );

  // 100 ns clock
  initial clk = 1'b0;
  always #50 clk = ~clk;

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    int fd;
    int code;
    int fields;
    int stepIdx;
    int waited;
    bit aborted;
    string line;
    rst = 1'b1;
    {stallF, stallD, stallE, stallM, flushD, flushE, flushM} = '0;
    instrIn = `NOP_INSTR;
    instrAck = 1'b0;
    {pcSrcE, retM, trapM, illegalBaseFaultD} = '0;
    pcTargetE = '0;
    privilegedNextPcM = '0;
    testName = '0;
    sigSel = '0;
    expVal = '0;
    stepValid = 1'b0;
    stepIdx = 0;
    aborted = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // memory read comes up one edge after reset
    waited = 0;
    while (!instrRead && waited < waitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (!instrRead) begin
      $display("timeout waiting for instrRead after reset");
      aborted = 1'b1;
    end
    fd = $fopen("bench/fetch_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/fetch_tests.txt");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %s %h",
                         testName, instrIn, instrAck, stallF, stallD, stallE, flushD,
                         flushE, pcSrcE, pcTargetE, retM, trapM, privilegedNextPcM,
                         illegalBaseFaultD, sigSel, expVal);
        if (fields != 16) begin
          $display("malformed test line: %s", line);
          aborted = 1'b1;
        end else begin
          // inputs change here on the falling edge, checker samples after the rising one
          stepValid = 1'b1;
          stepIdx++;
          waited = 0;
          while (checkedCount < stepIdx && waited < waitLimit) begin
            @(negedge clk);
            waited++;
          end
          if (checkedCount < stepIdx) begin
            $display("timeout waiting for the checker on test %0s", testName);
            aborted = 1'b1;
          end
        end
      end
    end
    stepValid = 1'b0;
    $display("checks run %0d, passed %0d, failed %0d", checkedCount,
             checkedCount - errorCount, errorCount);
    if (aborted || errorCount != 0 || stepIdx == 0) begin
      $display("=== FAIL ===");
    end else begin
      $display("=== PASS ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/fetch_tests.txt
# name instr ack stallF stallD stallE flushD flushE pcSrcE pcTargetE retM trapM privNextPc baseIll
# then the output to check and its expected value after the rising edge
rstHold      00000013 0 0 0 0 0 0 0 00000000 0 0 00000000 0 fstall  00000001
seqWord      00100093 1 0 0 0 0 0 0 00000000 0 0 00000000 0 pcF     00000204
seqHalf      00000505 1 0 0 0 0 0 0 00000000 0 0 00000000 0 pcF     00000206
seqHalfCarry 00000505 1 0 0 0 0 0 0 00000000 0 0 00000000 0 pcF     00000208
cLi          000052FD 1 0 0 0 0 0 0 00000000 0 0 00000000 0 instrD  FFF00293
cLw          00004044 1 0 0 0 0 0 0 00000000 0 0 00000000 0 instrD  00442483
cJr          00008082 1 0 0 0 0 0 0 00000000 0 0 00000000 0 instrD  00008067
cBeqz        0000C001 1 0 0 0 0 0 0 00000000 0 0 00000000 0 instrD  00040063
cZero        00000000 1 0 0 0 0 0 0 00000000 0 0 00000000 0 illegal 00000001
baseIllegal  00000013 1 0 0 0 0 0 0 00000000 0 0 00000000 1 illegal 00000001
branchTaken  00000013 1 0 0 0 0 0 1 00000400 0 0 00000000 0 pcF     00000400
mispredict   00000013 1 0 0 0 0 0 1 00000500 0 0 00000000 0 mispred 00000001
trapWins     00000013 1 0 0 0 0 0 1 00000600 0 1 00000700 0 pcF     00000700
retWins      00000013 1 0 0 0 0 0 1 00000A00 1 0 00000800 0 pcF     00000800
stallHold    00000013 1 1 0 0 0 0 0 00000000 0 0 00000000 0 pcF     00000800
ackMissing   00000013 0 0 0 0 0 0 0 00000000 0 0 00000000 0 pcF     00000800
jalRa        000000EF 1 0 0 0 0 0 0 00000000 0 0 00000000 0 pcF     00000804
retJalr      00008067 1 0 0 0 0 0 0 00000000 0 0 00000000 0 pcE     00000800
jalrX6       00030067 1 0 0 0 0 0 0 00000000 0 0 00000000 0 classM  00000010
jalX0        0000006F 1 0 0 0 0 0 0 00000000 0 0 00000000 0 classM  00000008
beqX0        00000063 1 0 0 0 0 0 0 00000000 0 0 00000000 0 classM  00000004
addiX2       00500113 1 0 0 0 0 0 0 00000000 0 0 00000000 0 classM  00000002
drainA       00000013 1 0 0 0 0 0 0 00000000 0 0 00000000 0 classM  00000001
drainB       00000013 1 0 0 0 0 0 0 00000000 0 0 00000000 0 instrM  00500113
drainC       00000013 1 0 0 0 0 0 0 00000000 0 0 00000000 0 pcM     00000818
jalFlushed   000000EF 1 0 0 0 0 0 0 00000000 0 0 00000000 0 pcF     00000828
flushExec    00B00213 1 0 0 0 0 1 0 00000000 0 0 00000000 0 pcF     0000082C
flushClass   00000013 1 0 0 0 0 0 0 00000000 0 0 00000000 0 classM  00000000
afterFlush   00000013 1 0 0 0 0 0 0 00000000 0 0 00000000 0 instrM  00B00213
stallExecPc  00000013 1 0 0 1 0 0 0 00000000 0 0 00000000 0 pcE     0000082C
stallExecLnk 00000013 1 0 0 1 0 0 0 00000000 0 0 00000000 0 pcLinkE 00000830
misTarget    00000013 1 0 0 0 0 0 1 00000901 0 0 00000000 0 misF    00000001
misAddress   00000013 1 0 0 0 0 0 0 00000000 0 0 00000000 0 misAdr  00000901
alignedPc    00000013 0 0 0 0 0 0 0 00000000 0 0 00000000 0 pcF     00000904

// File: design/decompress.sv
// RVC expander for a fixed RV32 subset; c.addi4spn, sp-relative forms and c.ebreak are illegal
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module decompress (
  input  logic [15:0]        parcel,
  output fetch_pkg::instrWordT expanded,
  output logic               illegal
);

  logic [4:0]  rdFull;
  logic [4:0]  rs2Full;
  logic [4:0]  rdPrime;
  logic [4:0]  rs1Prime;
  logic [11:0] ciImm;
  logic [11:0] memImm;
  logic [19:0] jImm;
  logic [6:0]  bImmHi;
  logic [4:0]  bImmLo;

  //////////////////////////////
  // operand and immediate slices
  //////////////////////////////

  assign rdFull   = parcel[11:7];
  assign rs2Full  = parcel[6:2];
  // three-bit register fields map to x8..x15
  assign rdPrime  = {2'b01, parcel[4:2]};
  assign rs1Prime = {2'b01, parcel[9:7]};

  // sign-extended 6-bit immediate of c.addi and c.li
  assign ciImm  = {{6{parcel[12]}}, parcel[12], parcel[6:2]};
  // word offset of c.lw and c.sw
  assign memImm = {5'b0, parcel[5], parcel[12:10], parcel[6], 2'b00};
  // c.j and c.jal offset laid out as instr[31:12] of a jal
  assign jImm   = {parcel[12], parcel[8], parcel[10:9], parcel[6], parcel[7],
                   parcel[2], parcel[11], parcel[5:3], parcel[12], {8{parcel[12]}}};
  // c.beqz and c.bnez offset split as instr[31:25] and instr[11:7]
  assign bImmHi = {{4{parcel[12]}}, parcel[6:5], parcel[2]};
  assign bImmLo = {parcel[11:10], parcel[4:3], parcel[12]};

  //////////////////////////////
  // expansion
  //////////////////////////////

  always_comb begin
    // anything not matched below stays a NOP
    expanded = `NOP_INSTR;
    illegal  = 1'b0;
    case (parcel[1:0])
      2'b00: begin
        case (parcel[15:13])
          // c.lw
          3'b010: expanded = {memImm, rs1Prime, 3'b010, rdPrime, 7'b0000011};
          // c.sw
          3'b110: expanded = {memImm[11:5], rdPrime, rs1Prime, 3'b010,
                              memImm[4:0], 7'b0100011};
          // includes the all-zero parcel
          default: illegal = 1'b1;
        endcase
      end
      2'b01: begin
        case (parcel[15:13])
          // c.addi, rd 0 is the c.nop hint
          3'b000: expanded = {ciImm, rdFull, 3'b000, rdFull, 7'b0010011};
          // c.jal links to x1
          3'b001: expanded = {jImm, 5'd1, 7'b1101111};
          // c.li
          3'b010: expanded = {ciImm, 5'd0, 3'b000, rdFull, 7'b0010011};
          3'b011: begin
            // rd 2 is c.addi16sp and a zero immediate is reserved
            if (rdFull == 5'd2 || {parcel[12], parcel[6:2]} == 6'd0) begin
              illegal = 1'b1;
            end else begin
              expanded = {{14{parcel[12]}}, parcel[12], parcel[6:2], rdFull, 7'b0110111};
            end
          end
          // c.j
          3'b101: expanded = {jImm, 5'd0, 7'b1101111};
          // c.beqz
          3'b110: expanded = {bImmHi, 5'd0, rs1Prime, 3'b000, bImmLo, 7'b1100011};
          // c.bnez
          3'b111: expanded = {bImmHi, 5'd0, rs1Prime, 3'b001, bImmLo, 7'b1100011};
          // ALU group is not in the subset
          default: illegal = 1'b1;
        endcase
      end
      2'b10: begin
        if (parcel[15:13] == 3'b100) begin
          if (rs2Full == 5'd0) begin
            // jr and jalr need a source, x0 here is reserved or c.ebreak
            if (rdFull == 5'd0) begin
              illegal = 1'b1;
            end else if (parcel[12]) begin
              expanded = {12'b0, rdFull, 3'b000, 5'd1, 7'b1100111};
            end else begin
              expanded = {12'b0, rdFull, 3'b000, 5'd0, 7'b1100111};
            end
          end else if (parcel[12]) begin
            // c.add
            expanded = {7'b0, rs2Full, rdFull, 3'b000, rdFull, 7'b0110011};
          end else begin
            // c.mv
            expanded = {7'b0, rs2Full, 5'd0, 3'b000, rdFull, 7'b0110011};
          end
        end else begin
          illegal = 1'b1;
        end
      end
      default: begin
        // full-width word, the upper half is merged outside
        expanded = {16'h0000, parcel};
      end
    endcase
  end

  // every legal result is a base-ISA encoding
  always_comb begin
    if (!illegal) begin
      assert (expanded[1:0] == 2'b11)
        else $error("expansion of %h is not a 32-bit encoding", parcel);
    end
  end

endmodule

`default_nettype wire

// File: design/fetchDecode.sv
// decode-stage register and instruction class; flushD only acts on a cycle with stallD low
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetchDecode (
  input  logic              clk,
  input  logic              rst,
  input  logic              stallD,
  input  logic              flushD,
  input  logic              illegalBaseFaultD,
  input  logic [31:0]       instrIn,
  input  logic [`XLEN-1:0]  pcF,
  input  logic [`XLEN-1:0]  pcPlusF,
  output logic [31:0]       instrD,
  output logic [`XLEN-1:0]  pcD,
  output logic [`XLEN-1:0]  pcLinkD,
  output logic [4:0]        classD,
  output logic              illegalInstrFaultD
);

  import fetch_pkg::*;

  localparam bit cSupported = `C_SUPPORTED;

  instrWordT instrRawD;
  instrWordT expandedD;
  instrWordT instrWordD;
  logic      isCompD;
  logic      illegalExpD;
  logic      illegalCompD;
  logic      isJal;
  logic      isJalr;
  logic      rdLink;
  logic      rs1Link;

  //////////////////////////////
  // decode-stage register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      instrRawD <= `NOP_INSTR;
      pcD       <= '0;
      pcLinkD   <= '0;
    end else if (!stallD) begin
      if (flushD) begin
        instrRawD <= `NOP_INSTR;
        pcD       <= '0;
        pcLinkD   <= '0;
      end else begin
        instrRawD <= instrIn;
        pcD       <= pcF;
        // pc+2 or pc+4 is the return address for jal and jalr
        pcLinkD   <= pcPlusF;
      end
    end
  end

  // expand 16-bit parcels
  assign isCompD = instrRawD.parcels.lo[1:0] != 2'b11;

  decompress decomp (
    .parcel   (instrRawD.parcels.lo),
    .expanded (expandedD),
    .illegal  (illegalExpD)
  );

  assign instrWordD = isCompD ? expandedD : instrRawD;
  assign instrD     = instrWordD;

  // any 16-bit parcel is illegal when C is off
  assign illegalCompD       = isCompD & (illegalExpD | ~cSupported);
  assign illegalInstrFaultD = illegalBaseFaultD | illegalCompD;

  //////////////////////////////
  // control-flow class
  //////////////////////////////

  assign isJal   = instrWordD.fields.opcode == 7'h6F;
  assign isJalr  = instrWordD.fields.opcode == 7'h67;
  // x1 and x5 both count as link registers
  assign rdLink  = (instrWordD.fields.rd & 5'h1B) == 5'h01;
  assign rs1Link = (instrWordD.fields.rs1 & 5'h1B) == 5'h01;

  assign classD[`CLASS_JAL] = (isJal | isJalr) & rdLink;
  // a jalr that also links is treated as a call, so classes stay exclusive
  assign classD[`CLASS_RET] = isJalr & rs1Link & ~rdLink;
  assign classD[`CLASS_JR]  = isJalr & ~rs1Link & ~rdLink;
  assign classD[`CLASS_J]   = isJal & ~rdLink;
  assign classD[`CLASS_BR]  = instrWordD.fields.opcode == 7'h63;

endmodule

`default_nettype wire

// File: design/fetchPipe.sv
// execute and memory registers; pc and link pc advance through a flush, only payload is cleared
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetchPipe (
  input  logic              clk,
  input  logic              rst,
  input  logic              stallE,
  input  logic              stallM,
  input  logic              flushE,
  input  logic              flushM,
  input  logic              misalignedE,
  input  logic              pcSrcE,
  input  logic [31:0]       instrD,
  input  logic [`XLEN-1:0]  pcD,
  input  logic [`XLEN-1:0]  pcLinkD,
  input  logic [`XLEN-1:0]  pcTargetE,
  input  logic [4:0]        classD,
  output logic [`XLEN-1:0]  pcE,
  output logic [`XLEN-1:0]  pcLinkE,
  output logic [`XLEN-1:0]  pcM,
  output logic [`XLEN-1:0]  misalignedAdrM,
  output logic [31:0]       instrM,
  output logic [4:0]        instrClassM,
  output logic              misalignedFaultM
);

  import fetch_pkg::*;

  instrWordT  instrE;
  logic [4:0] classE;

  //////////////////////////////
  // execute stage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      instrE  <= `NOP_INSTR;
      classE  <= '0;
      pcE     <= '0;
      pcLinkE <= '0;
    end else if (!stallE) begin
      // flushed slot becomes a NOP with no class
      instrE  <= flushE ? `NOP_INSTR : instrD;
      classE  <= flushE ? 5'd0 : classD;
      pcE     <= pcD;
      pcLinkE <= pcLinkD;
    end
  end

  //////////////////////////////
  // memory stage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      instrM           <= `NOP_INSTR;
      instrClassM      <= '0;
      pcM              <= '0;
      misalignedFaultM <= 1'b0;
      misalignedAdrM   <= '0;
    end else if (!stallM) begin
      instrM           <= flushM ? `NOP_INSTR : instrE;
      instrClassM      <= flushM ? 5'd0 : classE;
      pcM              <= pcE;
      misalignedFaultM <= flushM ? 1'b0 : misalignedE;
      // keep the last taken target for the trap handler
      if (pcSrcE) begin
        misalignedAdrM <= pcTargetE;
      end
    end
  end

  // class bits from decode must stay exclusive all the way down
  classOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(instrClassM))
    else $error("instrClassM has more than one bit: %b", instrClassM);

endmodule

`default_nettype wire

// File: design/fetchUnit.sv
// fetch unit top; no TLB, cache or predictor, memory must return the word at pcF and pulse instrAck
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetchUnit (
  input  logic              clk,
  input  logic              rst,
  input  logic              stallF,
  input  logic              stallD,
  input  logic              stallE,
  input  logic              stallM,
  input  logic              flushD,
  input  logic              flushE,
  input  logic              flushM,
  // instruction memory
  input  logic [31:0]       instrIn,
  input  logic              instrAck,
  output logic              instrRead,
  output logic              fetchStall,
  output logic [`XLEN-1:0]  pcF,
  // execute
  input  logic              pcSrcE,
  input  logic [`XLEN-1:0]  pcTargetE,
  output logic [`XLEN-1:0]  pcE,
  output logic [`XLEN-1:0]  pcLinkE,
  output logic              mispredictE,
  // memory
  input  logic              retM,
  input  logic              trapM,
  input  logic [`XLEN-1:0]  privilegedNextPcM,
  output logic [31:0]       instrD,
  output logic [31:0]       instrM,
  output logic [`XLEN-1:0]  pcM,
  output logic [4:0]        instrClassM,
  // faults
  input  logic              illegalBaseFaultD,
  output logic              illegalInstrFaultD,
  output logic              misalignedFaultM,
  output logic [`XLEN-1:0]  misalignedAdrM
);

  logic [`XLEN-1:0] pcPlusF;
  logic [`XLEN-1:0] pcD;
  logic [`XLEN-1:0] pcLinkD;
  logic [4:0]       classD;
  logic             misalignedE;

  pcSelect pcSel (
    .clk(clk), .rst(rst), .stallF(stallF), .instrAck(instrAck),
    .pcSrcE(pcSrcE), .retM(retM), .trapM(trapM), .instrIn(instrIn),
    .pcTargetE(pcTargetE), .pcLinkE(pcLinkE), .privilegedNextPcM(privilegedNextPcM),
    .pcF(pcF), .pcPlusF(pcPlusF), .instrRead(instrRead), .fetchStall(fetchStall),
    .mispredictE(mispredictE), .misalignedE(misalignedE)
  );

  fetchDecode dec (
    .clk(clk), .rst(rst), .stallD(stallD), .flushD(flushD),
    .illegalBaseFaultD(illegalBaseFaultD), .instrIn(instrIn), .pcF(pcF),
    .pcPlusF(pcPlusF), .instrD(instrD), .pcD(pcD), .pcLinkD(pcLinkD),
    .classD(classD), .illegalInstrFaultD(illegalInstrFaultD)
  );

  fetchPipe pipe (
    .clk(clk), .rst(rst), .stallE(stallE), .stallM(stallM), .flushE(flushE),
    .flushM(flushM), .misalignedE(misalignedE), .pcSrcE(pcSrcE), .instrD(instrD),
    .pcD(pcD), .pcLinkD(pcLinkD), .pcTargetE(pcTargetE), .classD(classD),
    .pcE(pcE), .pcLinkE(pcLinkE), .pcM(pcM), .misalignedAdrM(misalignedAdrM),
    .instrM(instrM), .instrClassM(instrClassM), .misalignedFaultM(misalignedFaultM)
  );

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
// shared fetch types; the word layout assumes RV32 base encodings only
`default_nettype none

package fetch_pkg;

  // standard R-type layout
  // I, S, B, U and J immediates are sliced out of these fields by the user
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instrFieldsT;

  // two 16-bit parcels as they sit in memory
  // lo holds the parcel at the lower address
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } instrParcelsT;

  // one fetched word, read either as a full instruction or as parcels
  typedef union packed {
    instrFieldsT  fields;
    instrParcelsT parcels;
  } instrWordT;

endpackage

`default_nettype wire

// File: design/pcSelect.sv
// pc generation; the pc only moves on an ack or while no read is pending, so redirects need one
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module pcSelect (
  input  logic              clk,
  input  logic              rst,
  input  logic              stallF,
  input  logic              instrAck,
  input  logic              pcSrcE,
  input  logic              retM,
  input  logic              trapM,
  input  logic [31:0]       instrIn,
  input  logic [`XLEN-1:0]  pcTargetE,
  input  logic [`XLEN-1:0]  pcLinkE,
  input  logic [`XLEN-1:0]  privilegedNextPcM,
  output logic [`XLEN-1:0]  pcF,
  output logic [`XLEN-1:0]  pcPlusF,
  output logic              instrRead,
  output logic              fetchStall,
  output logic              mispredictE,
  output logic              misalignedE
);

  localparam bit cSupported = `C_SUPPORTED;

  logic              rstQ;
  logic              readEn;
  logic              privChangeM;
  logic              compressedF;
  logic              misaligned;
  logic              pcEn;
  logic [`XLEN-3:0]  pcPlusUpperF;
  logic [`XLEN-1:0]  pcCorrectE;
  logic [`XLEN-1:0]  unalignedNextF;
  logic [`XLEN-1:0]  pcNextF;

  //////////////////////////////
  // reset and memory request
  //////////////////////////////

  // delayed reset picks the reset vector in the first cycle out of reset
  always_ff @(posedge clk) begin
    rstQ <= rst;
  end

  // read starts once reset is gone and then stays on
  always_ff @(posedge clk) begin
    if (rst) begin
      readEn <= 1'b0;
    end else begin
      readEn <= 1'b1;
    end
  end

  assign instrRead  = readEn;
  // waiting on memory
  assign fetchStall = instrRead & ~instrAck;

  //////////////////////////////
  // next pc
  //////////////////////////////

  // no predictor here so every taken branch is a mispredict
  assign mispredictE = pcSrcE;
  // fall-through target is the link pc when not taken
  assign pcCorrectE  = pcSrcE ? pcTargetE : pcLinkE;
  assign privChangeM = retM | trapM;

  always_comb begin
    if (rstQ) begin
      unalignedNextF = `RESET_VECTOR;
    end else if (privChangeM) begin
      unalignedNextF = privilegedNextPcM;
    end else if (mispredictE) begin
      unalignedNextF = pcCorrectE;
    end else begin
      unalignedNextF = pcPlusF;
    end
  end

  // instructions sit on halfword boundaries at least
  assign pcNextF = {unalignedNextF[`XLEN-1:1], 1'b0};

  // low bits 11 mean a full 32-bit word
  assign compressedF  = cSupported & (instrIn[1:0] != 2'b11);
  assign pcPlusUpperF = pcF[`XLEN-1:2] + (`XLEN-2)'(1);

  // +2 from an odd halfword carries into the upper bits
  always_comb begin
    if (compressedF) begin
      if (pcF[1]) begin
        pcPlusF = {pcPlusUpperF, 2'b00};
      end else begin
        pcPlusF = {pcF[`XLEN-1:2], 2'b10};
      end
    end else begin
      pcPlusF = {pcPlusUpperF, pcF[1:0]};
    end
  end

  // halfword targets are fine with C, otherwise words only
  assign misaligned  = cSupported ? unalignedNextF[0] : |unalignedNextF[1:0];
  assign misalignedE = misaligned & pcSrcE;

  // pc register
  assign pcEn = ~stallF & ~fetchStall;

  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= `RESET_VECTOR;
    end else if (pcEn) begin
      pcF <= pcNextF;
    end
  end

  pcHalfAligned: assert property (@(posedge clk) disable iff (rst) pcF[0] == 1'b0)
    else $error("pcF has bit 0 set: %h", pcF);

endmodule

`default_nettype wire

// File: include/fetch_params.svh
// fetch unit constants; XLEN above 32 is untested and class positions must stay within 4:0
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

//////////////////////////////
// datapath
//////////////////////////////

// address and pc width
`define XLEN 32

// first pc fetched after reset
`define RESET_VECTOR 32'h00000200

// addi x0, x0, 0 used to fill flushed slots
`define NOP_INSTR 32'h00000013

// 1 allows 16-bit instructions on halfword boundaries
// 0 requires word alignment of every fetch target
`define C_SUPPORTED 1

//////////////////////////////
// control-flow class bits
//////////////////////////////

// jal or jalr that links to x1 or x5
`define CLASS_JAL 4
// jalr through x1 or x5 with no link
`define CLASS_RET 3
// other jalr
`define CLASS_JR 2
// jal without link
`define CLASS_J 1
// conditional branch
`define CLASS_BR 0

`endif

// File: list.f
+incdir+include
design/fetch_pkg.sv
design/decompress.sv
design/pcSelect.sv
design/fetchDecode.sv
design/fetchPipe.sv
design/fetchUnit.sv
bench/fetchChecker.sv
bench/fetchTb.sv
